/* rmwSequencer.sv */
`timescale 1ns/100ps

module rmwSequencer import yRowPkg::*, wbBusPkg::*;
(
   input  logic                clock,
   input  logic                reset,
   input  logic                recValid,
   output logic                recTake,
   input  updateRecT           recHead,
   rowAccessIf.sequencer       access,
   output logic                updDone,
   output logic                busy
);

   typedef enum logic [2:0]
   {
      stIdle,
      stReadDiag,
      stWriteDiag,
      stReadNonDiag,
      stWriteNonDiag
   } seqStateT;

   seqStateT  state;
   seqStateT  nextAccess;
   updateRecT curRec;       // record being worked on
   logic      reqReg;
   logic      sameRow;
   logic      lastAccess;
   laneMaskT  firstMask;
   laneMaskT  secondMask;
   entryT     secondValue;
   rowDataT   mergedRow;

   assign sameRow = (curRec.diagAddr == curRec.nonDiagAddr);
   assign recTake = (state == stIdle) & recValid;
   assign busy    = (state != stIdle);

   // order of accesses, shared row ends after the diagonal write
   always_comb
   begin
      nextAccess = stIdle;
      lastAccess = 1'b0;
      case (state)
         stReadDiag:    nextAccess = stWriteDiag;
         stWriteDiag:
         begin
            nextAccess = sameRow ? stIdle : stReadNonDiag;
            lastAccess = sameRow;
         end
         stReadNonDiag: nextAccess = stWriteNonDiag;
         stWriteNonDiag:
         begin
            nextAccess = stIdle;
            lastAccess = 1'b1;
         end
         default:       nextAccess = stIdle;
      endcase
   end

   always_ff @(posedge clock)
   begin
      if (!reset)
      begin
         state   <= stIdle;
         reqReg  <= 1'b0;
         updDone <= 1'b0;
      end
      else
      begin
         updDone <= 1'b0;
         if (state == stIdle)
         begin
            if (recValid)
            begin
               state  <= stReadDiag;
               reqReg <= 1'b1;
            end
         end
         else if (access.done)
         begin
            state   <= nextAccess;
            reqReg  <= 1'b0;          // one idle cycle between accesses
            updDone <= lastAccess;
         end
         else if (!reqReg)
         begin
            reqReg <= 1'b1;
         end
      end
   end

   always_ff @(posedge clock)
   begin
      if (recTake)
         curRec <= recHead;
   end

   // change value goes first so the diagonal wins a shared lane
   assign firstMask   = (state == stWriteDiag && sameRow) ? curRec.nonDiagMask : '0;
   assign secondMask  = (state == stWriteNonDiag) ? curRec.nonDiagMask : curRec.diagMask;
   assign secondValue = (state == stWriteNonDiag) ? curRec.changeValue : curRec.diagValue;

   rowMerge merge
   (
      .oldRow      (access.rdata),      // held from the preceding read
      .firstMask   (firstMask),
      .firstValue  (curRec.changeValue),
      .secondMask  (secondMask),
      .secondValue (secondValue),
      .newRow      (mergedRow)
   );

   assign access.req   = reqReg;
   assign access.op    = (state == stWriteDiag || state == stWriteNonDiag) ? opWrite : opRead;
   assign access.addr  = (state == stReadNonDiag || state == stWriteNonDiag) ?
                         curRec.nonDiagAddr : curRec.diagAddr;
   assign access.wdata = mergedRow;

endmodule

/* rowAccessIf.sv */
`timescale 1ns/100ps

interface rowAccessIf import wbBusPkg::*; ();

   logic                   req;     // held until done is seen
   rowOpT                  op;
   logic [wbAddrWidth-1:0] addr;
   logic [wbDataWidth-1:0] wdata;
   logic [wbDataWidth-1:0] rdata;   // valid from done until next request
   logic                   done;    // one cycle per finished access

   modport sequencer
   (
      output req, op, addr, wdata,
      input  rdata, done
   );

   modport bus
   (
      input  req, op, addr, wdata,
      output rdata, done
   );

endinterface

/* rowMerge.sv */
`timescale 1ns/100ps

module rowMerge import yRowPkg::*;
(
   input  rowDataT  oldRow,
   input  laneMaskT firstMask,
   input  entryT    firstValue,
   input  laneMaskT secondMask,
   input  entryT    secondValue,
   output rowDataT  newRow
);

   // Each lane keeps its upper 16 bits.
   // Only the low entry field may be replaced, and second beats first.
   always_comb
   begin
      newRow = oldRow;
      for (int k = 0; k < laneCount; k++)
      begin
         if (secondMask[k])
         begin
            newRow[k*lanePitch +: entryWidth] = secondValue;
         end
         else if (firstMask[k])
         begin
            newRow[k*lanePitch +: entryWidth] = firstValue;
         end
      end
   end

endmodule

/* src.f */
yRowPkg.sv
wbBusPkg.sv
rowAccessIf.sv
updateQueue.sv
rowMerge.sv
rmwSequencer.sv
wbMaster.sv
yRowUpdater.sv
tbClock.sv
yRowUpdaterTb.sv

/* tbClock.sv */
`timescale 1ns/100ps

module tbClock
(
   output logic clock,
   output logic reset
);

   initial
   begin
      clock = 1'b0;
      forever #4 clock = ~clock;     // 8 ns period
   end

   initial
   begin
      reset = 1'b0;
      repeat (10) @(posedge clock);
      reset <= 1'b1;
   end

endmodule

/* updateQueue.sv */
`timescale 1ns/100ps

module updateQueue import yRowPkg::*;
(
   input  logic      clock,
   input  logic      reset,
   input  logic      inValid,
   output logic      inReady,
   input  updateRecT inRec,
   output logic      recValid,
   input  logic      recTake,
   output updateRecT recHead
);

   updateRecT  entries [0:1];
   logic       wrPtr;
   logic       rdPtr;
   logic [1:0] count;        // 0, 1 or 2 pending records
   logic       doWrite;
   logic       doTake;

   assign inReady  = (count != 2'd2);
   assign recValid = (count != 2'd0);
   assign recHead  = entries[rdPtr];

   assign doWrite = inValid & inReady;
   assign doTake  = recTake & recValid;

   always_ff @(posedge clock)
   begin
      if (!reset)
      begin
         wrPtr <= 1'b0;
         rdPtr <= 1'b0;
         count <= 2'd0;
      end
      else
      begin
         if (doWrite)
            wrPtr <= ~wrPtr;
         if (doTake)
            rdPtr <= ~rdPtr;
         if (doWrite && !doTake)
            count <= count + 2'd1;
         else if (doTake && !doWrite)
            count <= count - 2'd1;   // both at once leaves count alone
      end
   end

   always_ff @(posedge clock)
   begin
      if (doWrite)
         entries[wrPtr] <= inRec;
   end

endmodule

/* wbBusPkg.sv */
package wbBusPkg;

   // wishbone classic bus toward the Y memory
   localparam int wbAddrWidth = 11;     // row address, no byte offset
   localparam int wbDataWidth = 256;    // one full row per beat
   localparam int wbSelWidth  = 32;     // byte selects, always all ones

   // kind of row access requested by the sequencer
   typedef enum logic
   {
      opRead  = 1'b0,
      opWrite = 1'b1
   } rowOpT;

endpackage

/* wbMaster.sv */
`timescale 1ns/100ps

module wbMaster import yRowPkg::*, wbBusPkg::*;
(
   input  logic                  clock,
   input  logic                  reset,
   rowAccessIf.bus               access,
   output logic                  wbCyc,
   output logic                  wbStb,
   output logic                  wbWe,
   output rowAddrT               wbAdr,
   output rowDataT               wbDatO,
   output logic [wbSelWidth-1:0] wbSel,
   input  rowDataT               wbDatI,
   input  logic                  wbAck
);

   logic    doneReg;
   logic    launch;
   rowDataT rdataReg;

   // req is still high in the done cycle, so that one is skipped
   assign launch = access.req & ~wbCyc & ~doneReg;
   assign wbSel  = '1;          // whole rows only

   always_ff @(posedge clock)
   begin
      if (!reset)
      begin
         wbCyc   <= 1'b0;
         wbStb   <= 1'b0;
         wbWe    <= 1'b0;
         doneReg <= 1'b0;
      end
      else
      begin
         doneReg <= 1'b0;
         if (launch)
         begin
            wbCyc <= 1'b1;
            wbStb <= 1'b1;
            wbWe  <= (access.op == opWrite);
         end
         else if (wbCyc && wbAck)
         begin
            wbCyc   <= 1'b0;
            wbStb   <= 1'b0;
            wbWe    <= 1'b0;
            doneReg <= 1'b1;
         end
      end
   end

   always_ff @(posedge clock)
   begin
      if (launch)
      begin
         wbAdr  <= access.addr;     // held until ack
         wbDatO <= access.wdata;
      end
      if (wbCyc && wbAck && !wbWe)
         rdataReg <= wbDatI;
   end

   assign access.done  = doneReg;
   assign access.rdata = rdataReg;

endmodule

/* yRowPkg.sv */
package yRowPkg;

   // matrix row geometry
   localparam int rowAddrWidth = 11;     // 2048 rows in the Y memory
   localparam int rowWidth     = 256;
   localparam int laneCount    = 4;      // entries per row
   localparam int lanePitch    = 64;     // lane k starts at bit k*64
   localparam int entryWidth   = 48;     // {real, imag} in the low lane bits

   typedef logic [rowAddrWidth-1:0] rowAddrT;
   typedef logic [rowWidth-1:0]     rowDataT;
   typedef logic [entryWidth-1:0]   entryT;
   typedef logic [laneCount-1:0]    laneMaskT;   // bit k selects lane k

   // One update names a diagonal and a non-diagonal entry.
   // The two can share a row, in which case a single RMW covers both.
   typedef struct packed
   {
      rowAddrT  diagAddr;
      rowAddrT  nonDiagAddr;
      laneMaskT diagMask;
      laneMaskT nonDiagMask;
      entryT    diagValue;      // freshly computed diagonal
      entryT    changeValue;    // non-diagonal change value
   } updateRecT;

endpackage

/* yRowUpdater.sv */
`timescale 1ns/100ps

module yRowUpdater import yRowPkg::*, wbBusPkg::*;
(
   input  logic                  clock,
   input  logic                  reset,
   input  logic                  updValid,
   output logic                  updReady,
   input  rowAddrT               updDiagAddr,
   input  rowAddrT               updNonDiagAddr,
   input  laneMaskT              updDiagMask,
   input  laneMaskT              updNonDiagMask,
   input  entryT                 updDiagValue,
   input  entryT                 updChangeValue,
   output logic                  wbCyc,
   output logic                  wbStb,
   output logic                  wbWe,
   output rowAddrT               wbAdr,
   output rowDataT               wbDatO,
   output logic [wbSelWidth-1:0] wbSel,
   input  rowDataT               wbDatI,
   input  logic                  wbAck,
   output logic                  updDone,
   output logic                  busy
);

   updateRecT inRec;
   updateRecT recHead;
   logic      recValid;
   logic      recTake;

   assign inRec.diagAddr    = updDiagAddr;
   assign inRec.nonDiagAddr = updNonDiagAddr;
   assign inRec.diagMask    = updDiagMask;
   assign inRec.nonDiagMask = updNonDiagMask;
   assign inRec.diagValue   = updDiagValue;
   assign inRec.changeValue = updChangeValue;

   rowAccessIf access();

   updateQueue queue
   (
      .clock    (clock),
      .reset    (reset),
      .inValid  (updValid),
      .inReady  (updReady),
      .inRec    (inRec),
      .recValid (recValid),
      .recTake  (recTake),
      .recHead  (recHead)
   );

   rmwSequencer sequencer
   (
      .clock    (clock),
      .reset    (reset),
      .recValid (recValid),
      .recTake  (recTake),
      .recHead  (recHead),
      .access   (access),
      .updDone  (updDone),
      .busy     (busy)
   );

   wbMaster master
   (
      .clock  (clock),
      .reset  (reset),
      .access (access),
      .wbCyc  (wbCyc),
      .wbStb  (wbStb),
      .wbWe   (wbWe),
      .wbAdr  (wbAdr),
      .wbDatO (wbDatO),
      .wbSel  (wbSel),
      .wbDatI (wbDatI),
      .wbAck  (wbAck)
   );

endmodule

/* yRowUpdaterTb.sv */
`timescale 1ns/100ps

module yRowUpdaterTb import yRowPkg::*, wbBusPkg::*; ();

   localparam int recCount   = 12;
   localparam int memRows    = 1 << rowAddrWidth;
   localparam int cycleLimit = recCount * 4 * 6 + 400;   // gaps and wait states in margin

   typedef struct packed
   {
      logic    we;
      rowAddrT adr;
      rowDataT dat;
   } accessT;

   logic                  clock;
   logic                  reset;
   logic                  updValid;
   logic                  updReady;
   rowAddrT               updDiagAddr;
   rowAddrT               updNonDiagAddr;
   laneMaskT              updDiagMask;
   laneMaskT              updNonDiagMask;
   entryT                 updDiagValue;
   entryT                 updChangeValue;
   logic                  wbCyc;
   logic                  wbStb;
   logic                  wbWe;
   rowAddrT               wbAdr;
   rowDataT               wbDatO;
   logic [wbSelWidth-1:0] wbSel;
   rowDataT               wbDatI;
   logic                  wbAck;
   logic                  updDone;
   logic                  busy;

   // stimulus table with one row per update record
   rowAddrT  tabDiagAddr    [recCount];
   rowAddrT  tabNonDiagAddr [recCount];
   laneMaskT tabDiagMask    [recCount];
   laneMaskT tabNonDiagMask [recCount];
   entryT    tabDiagValue   [recCount];
   entryT    tabChangeValue [recCount];
   int       tabGap         [recCount];   // idle cycles before the record is offered

   rowDataT  yMem      [memRows];         // what the bus sees
   rowDataT  shadowMem [memRows];         // expected contents
   accessT   accessLog [$];

   integer   seed;
   int       errorCount;
   int       doneCount;
   int       cycleCount;
   int       waitLeft;
   logic     inCycle;
   logic     sawFull;
   logic     holdValid;
   rowAddrT  holdAdr;
   logic     holdWe;
   rowDataT  holdDat;
   accessT   newAccess;

   tbClock clockGen
   (
      .clock (clock),
      .reset (reset)
   );

   yRowUpdater uut
   (
      .clock          (clock),
      .reset          (reset),
      .updValid       (updValid),
      .updReady       (updReady),
      .updDiagAddr    (updDiagAddr),
      .updNonDiagAddr (updNonDiagAddr),
      .updDiagMask    (updDiagMask),
      .updNonDiagMask (updNonDiagMask),
      .updDiagValue   (updDiagValue),
      .updChangeValue (updChangeValue),
      .wbCyc          (wbCyc),
      .wbStb          (wbStb),
      .wbWe           (wbWe),
      .wbAdr          (wbAdr),
      .wbDatO         (wbDatO),
      .wbSel          (wbSel),
      .wbDatI         (wbDatI),
      .wbAck          (wbAck),
      .updDone        (updDone),
      .busy           (busy)
   );

   task automatic failRun(input string what);
      begin
         $display("%s", what);
         $display("Errors found");
         $fatal(1);
      end
   endtask

   task automatic checkValue(input string name, input logic [255:0] got,
                             input logic [255:0] expected);
      begin
         if (got !== expected)
         begin
            errorCount = errorCount + 1;
            $display("ERROR %s got %h expected %h", name, got, expected);
            failRun("stopping at the first mismatch");
         end
      end
   endtask

   // low 48 bits of each selected lane take the value
   function automatic rowDataT insertLanes(rowDataT row, laneMaskT mask, entryT value);
      rowDataT result;
      result = row;
      for (int lane = 0; lane < laneCount; lane++)
      begin
         if (mask[lane])
            result[lane*lanePitch +: entryWidth] = value;
      end
      return result;
   endfunction

   task automatic setRow(input int i, input rowAddrT d, input rowAddrT nd,
                         input laneMaskT dm, input laneMaskT ndm,
                         input entryT dv, input entryT cv, input int gap);
      begin
         tabDiagAddr[i]    = d;
         tabNonDiagAddr[i] = nd;
         tabDiagMask[i]    = dm;
         tabNonDiagMask[i] = ndm;
         tabDiagValue[i]   = dv;
         tabChangeValue[i] = cv;
         tabGap[i]         = gap;
      end
   endtask

   task automatic loadTable();
      begin
         // index, diagAddr, nonDiagAddr, diagMask, nonDiagMask, diagValue, changeValue, gap
         setRow(0,  11'h005, 11'h005, 4'b0001, 4'b0100, 48'h1111_2222_3333, 48'h0aaa_0bbb_0ccc, 3);
         setRow(1,  11'h010, 11'h010, 4'b0010, 4'b0010, 48'h4444_5555_6666, 48'h0ddd_0eee_0fff, 2);
         setRow(2,  11'h020, 11'h3ff, 4'b1000, 4'b0001, 48'h7777_8888_9999, 48'h1234_5678_9abc, 0);
         setRow(3,  11'h7ff, 11'h000, 4'b0100, 4'b0010, 48'hfedc_ba98_7654, 48'h0f0f_0f0f_0f0f, 0);
         setRow(4,  11'h123, 11'h456, 4'b1111, 4'b0110, 48'haaaa_bbbb_cccc, 48'h5a5a_a5a5_5a5a, 0);
         setRow(5,  11'h200, 11'h201, 4'b0000, 4'b0000, 48'hdead_beef_0001, 48'hcafe_f00d_0002, 0);
         setRow(6,  11'h300, 11'h300, 4'b1010, 4'b0101, 48'h0123_4567_89ab, 48'hcdef_0123_4567, 5);
         setRow(7,  11'h020, 11'h005, 4'b0010, 4'b1000, 48'h1357_9bdf_2468, 48'h8642_fdb9_7531, 0);
         setRow(8,  11'h3ff, 11'h020, 4'b0001, 4'b0001, 48'hffff_0000_ffff, 48'h0000_ffff_0000, 0);
         setRow(9,  11'h555, 11'h555, 4'b0000, 4'b1100, 48'h2222_3333_4444, 48'h9999_aaaa_bbbb, 1);
         setRow(10, 11'h0aa, 11'h055, 4'b0110, 4'b0000, 48'h6666_7777_8888, 48'h3c3c_3c3c_3c3c, 0);
         setRow(11, 11'h123, 11'h123, 4'b1111, 4'b1111, 48'h0bad_c0de_0bad, 48'h0001_0002_0003, 0);
      end
   endtask

   task automatic preloadMemory();
      begin
         for (int r = 0; r < memRows; r++)
         begin
            for (int w = 0; w < rowWidth / 32; w++)
               yMem[r][w*32 +: 32] = $random(seed);
            shadowMem[r] = yMem[r];
         end
      end
   endtask

   // checks the accesses of one finished record against the shadow copy
   task automatic verifyRecord(input int idx);
      rowAddrT d;
      rowAddrT nd;
      logic    sameRow;
      rowDataT expRow;
      accessT  acc;
      begin
         d       = tabDiagAddr[idx];
         nd      = tabNonDiagAddr[idx];
         sameRow = (d == nd);
         checkValue("access count", accessLog.size(), sameRow ? 2 : 4);
         if (sameRow)   // diagonal applied last so it wins a shared lane
            expRow = insertLanes(insertLanes(shadowMem[d], tabNonDiagMask[idx],
                                 tabChangeValue[idx]), tabDiagMask[idx], tabDiagValue[idx]);
         else
            expRow = insertLanes(shadowMem[d], tabDiagMask[idx], tabDiagValue[idx]);
         acc = accessLog.pop_front();
         checkValue("wbWe", acc.we, 1'b0);
         checkValue("wbAdr", acc.adr, d);
         acc = accessLog.pop_front();
         checkValue("wbWe", acc.we, 1'b1);
         checkValue("wbAdr", acc.adr, d);
         checkValue("wbDatO", acc.dat, expRow);
         shadowMem[d] = expRow;
         if (!sameRow)
         begin
            expRow = insertLanes(shadowMem[nd], tabNonDiagMask[idx], tabChangeValue[idx]);
            acc = accessLog.pop_front();
            checkValue("wbWe", acc.we, 1'b0);
            checkValue("wbAdr", acc.adr, nd);
            acc = accessLog.pop_front();
            checkValue("wbWe", acc.we, 1'b1);
            checkValue("wbAdr", acc.adr, nd);
            checkValue("wbDatO", acc.dat, expRow);
            shadowMem[nd] = expRow;
         end
      end
   endtask

   // wishbone memory with 0 to 3 wait states per cycle
   always @(posedge clock)
   begin
      if (!reset)
      begin
         wbAck   <= 1'b0;
         inCycle = 1'b0;
      end
      else if (wbAck)
      begin
         wbAck   <= 1'b0;           // master drops cyc on this edge
         inCycle = 1'b0;
      end
      else if (wbCyc && wbStb)
      begin
         if (!inCycle)
         begin
            inCycle  = 1'b1;
            waitLeft = {$random(seed)} % 4;
         end
         if (waitLeft == 0)
         begin
            wbAck <= 1'b1;
            newAccess.we  = wbWe;
            newAccess.adr = wbAdr;
            if (wbWe)
            begin
               yMem[wbAdr]   = wbDatO;
               newAccess.dat = wbDatO;
            end
            else
            begin
               wbDatI        <= yMem[wbAdr];
               newAccess.dat = yMem[wbAdr];
            end
            accessLog.push_back(newAccess);
         end
         else
            waitLeft = waitLeft - 1;
      end
   end

   // request must stay put while stb waits for ack
   always @(posedge clock)
   begin
      if (reset)
      begin
         if (holdValid && wbCyc && wbStb)
         begin
            checkValue("wbAdr", wbAdr, holdAdr);
            checkValue("wbWe", wbWe, holdWe);
            checkValue("wbDatO", wbDatO, holdDat);
         end
         if (wbCyc)
         begin
            checkValue("wbSel", wbSel, {wbSelWidth{1'b1}});
            checkValue("busy", busy, 1'b1);   // every bus cycle belongs to a record
         end
         holdValid = wbCyc && wbStb && !wbAck;
         holdAdr   = wbAdr;
         holdWe    = wbWe;
         holdDat   = wbDatO;
         if (!updReady)
            sawFull = 1'b1;
      end
   end

   always @(posedge clock)
   begin
      if (reset && updDone)
      begin
         if (doneCount >= recCount)
            failRun("more updDone pulses than records offered");
         verifyRecord(doneCount);
         doneCount = doneCount + 1;
      end
   end

   always @(posedge clock)
   begin
      cycleCount = cycleCount + 1;
      if (cycleCount > cycleLimit)
         failRun("TIMEOUT the update records did not finish in time");
   end

   initial
   begin
      seed           = 32'h2a06;
      errorCount     = 0;
      doneCount      = 0;
      cycleCount     = 0;
      waitLeft       = 0;
      inCycle        = 1'b0;
      sawFull        = 1'b0;
      holdValid      = 1'b0;
      updValid       = 1'b0;
      updDiagAddr    = '0;
      updNonDiagAddr = '0;
      updDiagMask    = '0;
      updNonDiagMask = '0;
      updDiagValue   = '0;
      updChangeValue = '0;
      wbDatI         = '0;
      wbAck          = 1'b0;
      loadTable();
      preloadMemory();

      @(posedge reset);
      @(negedge clock);
      checkValue("wbCyc", wbCyc, 1'b0);
      checkValue("wbStb", wbStb, 1'b0);
      checkValue("wbWe", wbWe, 1'b0);
      checkValue("updDone", updDone, 1'b0);
      checkValue("busy", busy, 1'b0);
      checkValue("updReady", updReady, 1'b1);

      @(posedge clock);
      for (int idx = 0; idx < recCount; idx++)
      begin
         if (tabGap[idx] > 0)
         begin
            updValid <= 1'b0;
            repeat (tabGap[idx]) @(posedge clock);
         end
         updValid       <= 1'b1;
         updDiagAddr    <= tabDiagAddr[idx];
         updNonDiagAddr <= tabNonDiagAddr[idx];
         updDiagMask    <= tabDiagMask[idx];
         updNonDiagMask <= tabNonDiagMask[idx];
         updDiagValue   <= tabDiagValue[idx];
         updChangeValue <= tabChangeValue[idx];
         @(posedge clock);
         while (!updReady)          // held until accepted
            @(posedge clock);
      end
      updValid <= 1'b0;

      while (doneCount < recCount)
         @(posedge clock);
      @(posedge clock);
      checkValue("busy", busy, 1'b0);
      checkValue("updReady low while two records pending", sawFull, 1'b1);
      checkValue("leftover accesses", accessLog.size(), 0);

      if (errorCount == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule
